// ==== sources.f ====
verilog/vwrite_pkg.sv
verilog/word_stream_if.sv
verilog/addr_gen.sv
verilog/mem_reader.sv
verilog/burst_writer.sv
verilog/write_ctrl.sv
verilog/vwrite_top.sv
verification/vwrite_assert.sv
verification/tb_vwrite.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= tb_vwrite
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
SIM        = $(OBJ_DIR)/V$(TOP)
PASS_MSG   = >>> PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$($(SIM) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/tb_vwrite.sv ====
module tb_vwrite;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int ADDR_W     = vwrite_pkg::ADDR_W;
   localparam int DATA_W     = vwrite_pkg::DATA_W;
   localparam int AXI_ADDR_W = vwrite_pkg::AXI_ADDR_W;
   localparam int PERIOD_W   = vwrite_pkg::PERIOD_W;
   localparam int LEN_W      = vwrite_pkg::LEN_W;
   localparam int DELAY_W    = vwrite_pkg::DELAY_W;
   localparam int TIMEOUT    = 1000;

   logic                  clk;
   logic                  rst;
   logic                  run_i;
   logic                  running_i;
   logic                  done_o;
   logic                  ping_pong_i;
   logic                  write_enable_i;
   logic [AXI_ADDR_W-1:0] ext_addr_i;
   logic [AXI_ADDR_W-1:0] addr_shift_i;
   logic [LEN_W-1:0]      burst_len_i;
   logic [ADDR_W-1:0]     amount_minus_one_i;
   logic [ADDR_W-1:0]     store_start_i;
   logic [PERIOD_W-1:0]   store_per_i;
   logic [PERIOD_W-1:0]   store_duty_i;
   logic [ADDR_W-1:0]     store_incr_i;
   logic [ADDR_W-1:0]     store_shift_i;
   logic [ADDR_W-1:0]     store_iter_i;
   logic [DELAY_W-1:0]    store_delay_i;
   logic [ADDR_W-1:0]     read_start_i;
   logic [PERIOD_W-1:0]   read_per_i;
   logic [ADDR_W-1:0]     read_incr_i;
   logic [ADDR_W-1:0]     read_shift_i;
   logic [ADDR_W-1:0]     read_iter_i;
   logic [DATA_W-1:0]     in_data_i;
   logic                  mem_wr_o;
   logic [ADDR_W-1:0]     mem_wr_addr_o;
   logic [DATA_W-1:0]     mem_wr_data_o;
   logic                  mem_rd_o;
   logic [ADDR_W-1:0]     mem_rd_addr_o;
   logic [DATA_W-1:0]     mem_rd_data_i;
   logic                  bus_valid_o;
   logic                  bus_ready_i;
   logic [AXI_ADDR_W-1:0] bus_addr_o;
   logic [DATA_W-1:0]     bus_wdata_o;
   logic [DATA_W/8-1:0]   bus_wstrb_o;
   logic [LEN_W-1:0]      bus_len_o;
   logic                  bus_last_i;

   // buffer model and its expected contents
   logic [DATA_W-1:0]     mem [0:2**ADDR_W-1];
   logic [DATA_W-1:0]     ref_mem [0:2**ADDR_W-1];
   // input word per cycle after run and beats taken by the slave
   logic [DATA_W-1:0]     words[$];
   logic [AXI_ADDR_W-1:0] got_addr[$];
   logic [DATA_W-1:0]     got_data[$];
   logic [LEN_W-1:0]      got_len[$];
   int                    beat_cnt;
   logic                  bank;

   vwrite_top uut (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [DATA_W-1:0] fill_word(input int unsigned a);
      return DATA_W'(32'hc3a5_0000 + a * 32'h0002_0001);
   endfunction

   task automatic stop_sim(input string msg);
      $display("%s", msg);
      $display(">>> FAIL");
      $fatal(1, "simulation stopped");
   endtask

   // one-cycle read latency
   always @(posedge clk) begin
      if (mem_wr_o) begin
         mem[mem_wr_addr_o] <= mem_wr_data_o;
      end
      if (mem_rd_o) begin
         mem_rd_data_i <= mem[mem_rd_addr_o];
      end
   end

   always @(negedge clk) begin
      if (uut.chk.errors != 0) begin
         stop_sim("an assertion in vwrite_assert failed");
      end
   end

   // new input word, random ready and beat capture on the falling edge
   task automatic tick();
      logic rdy;
      logic vld;
      @(negedge clk);
      vld = bus_valid_o;
      rdy = ($urandom % 3) != 0;
      if (vld && rdy) begin
         got_addr.push_back(bus_addr_o);
         got_data.push_back(bus_wdata_o);
         got_len.push_back(bus_len_o);
      end
      in_data_i   = DATA_W'($urandom);
      bus_ready_i = rdy;
      bus_last_i  = rdy && (beat_cnt == int'(burst_len_i) - 1);
      words.push_back(in_data_i);
      if (vld && rdy) begin
         beat_cnt = (beat_cnt == int'(burst_len_i) - 1) ? 0 : beat_cnt + 1;
      end
   endtask

   task automatic check_run(input logic pp, input logic we);
      int                idx;
      int                n;
      int                b;
      logic [ADDR_W-1:0] raw;
      logic [ADDR_W-1:0] a;
      logic [DATA_W-1:0] exp_data[$];
      // read side sees the buffer as it was before this run
      for (int i = 0; i < int'(read_iter_i); i++) begin
         for (int s = 0; s < int'(read_per_i); s++) begin
            raw = read_start_i + ADDR_W'(i) * read_shift_i + ADDR_W'(s) * read_incr_i;
            a = pp ? {!bank, raw[ADDR_W-2:0]} : raw;
            exp_data.push_back(ref_mem[a]);
         end
      end
      idx = int'(store_delay_i);
      for (int i = 0; i < int'(store_iter_i); i++) begin
         for (int s = 0; s < int'(store_per_i); s++) begin
            raw = store_start_i + ADDR_W'(i) * store_shift_i + ADDR_W'(s) * store_incr_i;
            a = pp ? {bank, raw[ADDR_W-2:0]} : raw;
            if (s < int'(store_duty_i)) begin
               ref_mem[a] = words[idx];
            end
            idx++;
         end
      end
      n = we ? int'(amount_minus_one_i) + 1 : 0;
      if (got_data.size() != n) begin
         stop_sim($sformatf("Fail at %0t ns: %0d beats, expected %0d", $time,
                            got_data.size(), n));
      end
      for (int k = 0; k < n; k++) begin
         b = k / int'(burst_len_i);
         if (got_data[k] !== exp_data[k] || got_len[k] !== burst_len_i ||
             got_addr[k] !== ext_addr_i + AXI_ADDR_W'(b) * addr_shift_i) begin
            stop_sim($sformatf("Fail at %0t ns: beat %0d addr %h data %h len %0d",
                               $time, k, got_addr[k], got_data[k], got_len[k]));
         end
      end
   endtask

   task automatic run_and_check(input logic pp, input logic we);
      int t;
      @(negedge clk);
      ping_pong_i    = pp;
      write_enable_i = we;
      run_i          = 1'b1;
      running_i      = 1'b1;
      bank           = pp ? !bank : 1'b0;
      beat_cnt       = 0;
      words.delete();
      got_addr.delete();
      got_data.delete();
      got_len.delete();
      tick();
      run_i = 1'b0;
      t = 0;
      while (!done_o) begin
         if (t == TIMEOUT) begin
            stop_sim("timeout waiting for done_o after run");
         end
         tick();
         t++;
      end
      running_i = 1'b0;
      check_run(pp, we);
   endtask

   initial begin
      void'($urandom(32'hf298));
      rst                = 1'b1;
      run_i              = 1'b0;
      running_i          = 1'b0;
      ping_pong_i        = 1'b0;
      write_enable_i     = 1'b0;
      ext_addr_i         = 32'h8000_1000;
      addr_shift_i       = 32'h0000_0100;
      burst_len_i        = 8'd6;
      amount_minus_one_i = 10'd19;
      store_start_i      = 10'd0;
      store_per_i        = 8'd6;
      store_duty_i       = 8'd4;
      store_incr_i       = 10'd3;
      store_shift_i      = 10'd32;
      store_iter_i       = 10'd5;
      store_delay_i      = 7'd5;
      read_start_i       = 10'd0;
      read_per_i         = 8'd4;
      read_incr_i        = 10'd3;
      read_shift_i       = 10'd32;
      read_iter_i        = 10'd5;
      in_data_i          = '0;
      mem_rd_data_i      = '0;
      bus_ready_i        = 1'b0;
      bus_last_i         = 1'b0;
      bank               = 1'b0;
      beat_cnt           = 0;
      for (int unsigned a = 0; a < 2**ADDR_W; a++) begin
         mem[ADDR_W'(a)]     = fill_word(a);
         ref_mem[ADDR_W'(a)] = fill_word(a);
      end
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      repeat (4) @(negedge clk);
      // store only without a transfer
      run_and_check(1'b0, 1'b0);
      // 20 words in bursts of 6 with banks swapping each run
      repeat (3) run_and_check(1'b1, 1'b1);
      if (uut.chk.errors == 0) begin
         $display(">>> PASS");
         $finish;
      end else begin
         stop_sim("an assertion in vwrite_assert failed");
      end
   end

endmodule

// ==== verification/vwrite_assert.sv ====
module vwrite_assert #(
   parameter int ADDR_W     = vwrite_pkg::ADDR_W,
   parameter int DATA_W     = vwrite_pkg::DATA_W,
   parameter int AXI_ADDR_W = vwrite_pkg::AXI_ADDR_W,
   parameter int PERIOD_W   = vwrite_pkg::PERIOD_W,
   parameter int LEN_W      = vwrite_pkg::LEN_W,
   parameter int DELAY_W    = vwrite_pkg::DELAY_W
) (
   input logic                  clk,
   input logic                  rst,
   input logic                  run_i,
   input logic                  ping_pong_i,
   input logic                  write_enable_i,
   input logic                  done_o,
   input logic [ADDR_W-1:0]     store_start_i,
   input logic [PERIOD_W-1:0]   store_per_i,
   input logic [PERIOD_W-1:0]   store_duty_i,
   input logic [ADDR_W-1:0]     store_incr_i,
   input logic [ADDR_W-1:0]     store_shift_i,
   input logic [ADDR_W-1:0]     store_iter_i,
   input logic [DELAY_W-1:0]    store_delay_i,
   input logic                  mem_wr_o,
   input logic [ADDR_W-1:0]     mem_wr_addr_o,
   input logic                  mem_rd_o,
   input logic [ADDR_W-1:0]     mem_rd_addr_o,
   input logic                  bus_valid_o,
   input logic                  bus_ready_i,
   input logic [AXI_ADDR_W-1:0] bus_addr_o,
   input logic [DATA_W-1:0]     bus_wdata_o,
   input logic [DATA_W/8-1:0]   bus_wstrb_o,
   input logic [LEN_W-1:0]      bus_len_o
);
   timeunit 1ns;
   timeprecision 1ps;

   int unsigned errors = 0;

   // reference state of the store loop
   logic                started;
   logic                active;
   logic                bank;
   logic [DELAY_W-1:0]  dly;
   logic [PERIOD_W-1:0] step;
   logic [ADDR_W-1:0]   iter;
   logic [ADDR_W-1:0]   raw;
   logic [ADDR_W-1:0]   exp_addr;
   logic                stepping;

   assign stepping = active && (dly == '0);
   assign raw      = store_start_i + iter * store_shift_i + ADDR_W'(step) * store_incr_i;
   assign exp_addr = ping_pong_i ? {bank, raw[ADDR_W-2:0]} : raw;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         started <= 1'b0;
         active  <= 1'b0;
         bank    <= 1'b0;
         dly     <= '0;
         step    <= '0;
         iter    <= '0;
      end else if (run_i) begin
         started <= 1'b1;
         active  <= 1'b1;
         bank    <= ping_pong_i ? !bank : 1'b0;
         dly     <= store_delay_i;
         step    <= '0;
         iter    <= '0;
      end else if (active) begin
         if (dly != '0) begin
            dly <= dly - 1'b1;
         end else if (step == store_per_i - 1'b1) begin
            step <= '0;
            if (iter == store_iter_i - 1'b1) begin
               active <= 1'b0;
            end else begin
               iter <= iter + 1'b1;
            end
         end else begin
            step <= step + 1'b1;
         end
      end
   end

   idle_until_run: assert property (@(posedge clk)
      (rst || !started) |-> (done_o && !bus_valid_o && !mem_wr_o && !mem_rd_o))
      else begin
         errors++;
         $error("outputs not idle before the first run");
      end

   no_write_in_delay: assert property (@(posedge clk) disable iff (rst)
      (active && dly != '0) |-> !mem_wr_o)
      else begin
         errors++;
         $error("buffer written during the start delay");
      end

   // write only while the step index is below duty
   store_flag: assert property (@(posedge clk) disable iff (rst)
      stepping |-> (mem_wr_o == (step < store_duty_i)))
      else begin
         errors++;
         $error("store flag differs from duty rule");
      end

   store_addr: assert property (@(posedge clk) disable iff (rst)
      (stepping && mem_wr_o) |-> (mem_wr_addr_o == exp_addr))
      else begin
         errors++;
         $error("store address differs from loop rule");
      end

   no_stray_write: assert property (@(posedge clk) disable iff (rst)
      !active |-> !mem_wr_o)
      else begin
         errors++;
         $error("buffer written outside the store loop");
      end

   read_bank: assert property (@(posedge clk) disable iff (rst)
      (ping_pong_i && mem_rd_o) |-> (mem_rd_addr_o[ADDR_W-1] == !bank))
      else begin
         errors++;
         $error("read bank is not the inverse of the store bank");
      end

   bus_hold: assert property (@(posedge clk) disable iff (rst)
      (bus_valid_o && !bus_ready_i) |=> (bus_valid_o && $stable(bus_addr_o)
         && $stable(bus_wdata_o) && $stable(bus_len_o)))
      else begin
         errors++;
         $error("databus beat changed while stalled");
      end

   // every beat writes all bytes
   bus_strobe: assert property (@(posedge clk) disable iff (rst)
      bus_valid_o |-> (bus_wstrb_o == '1))
      else begin
         errors++;
         $error("databus strobe is not all ones");
      end

   write_off: assert property (@(posedge clk) disable iff (rst)
      !write_enable_i |-> (!bus_valid_o && !mem_rd_o))
      else begin
         errors++;
         $error("transfer activity with writing disabled");
      end

endmodule

bind vwrite_top vwrite_assert #(
   .ADDR_W    (ADDR_W),
   .DATA_W    (DATA_W),
   .AXI_ADDR_W(AXI_ADDR_W),
   .PERIOD_W  (PERIOD_W),
   .LEN_W     (LEN_W),
   .DELAY_W   (DELAY_W)
) chk (.*);

// ==== verilog/vwrite_top.sv ====
module vwrite_top #(
   parameter int ADDR_W     = vwrite_pkg::ADDR_W,
   parameter int DATA_W     = vwrite_pkg::DATA_W,
   parameter int AXI_ADDR_W = vwrite_pkg::AXI_ADDR_W,
   parameter int PERIOD_W   = vwrite_pkg::PERIOD_W,
   parameter int LEN_W      = vwrite_pkg::LEN_W,
   parameter int DELAY_W    = vwrite_pkg::DELAY_W
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  run_i,
   input  logic                  running_i,
   output logic                  done_o,
   input  logic                  ping_pong_i,
   input  logic                  write_enable_i,
   input  logic [AXI_ADDR_W-1:0] ext_addr_i,
   input  logic [AXI_ADDR_W-1:0] addr_shift_i,
   input  logic [LEN_W-1:0]      burst_len_i,
   input  logic [ADDR_W-1:0]     amount_minus_one_i,
   input  logic [ADDR_W-1:0]     store_start_i,
   input  logic [PERIOD_W-1:0]   store_per_i,
   input  logic [PERIOD_W-1:0]   store_duty_i,
   input  logic [ADDR_W-1:0]     store_incr_i,
   input  logic [ADDR_W-1:0]     store_shift_i,
   input  logic [ADDR_W-1:0]     store_iter_i,
   input  logic [DELAY_W-1:0]    store_delay_i,
   input  logic [ADDR_W-1:0]     read_start_i,
   input  logic [PERIOD_W-1:0]   read_per_i,
   input  logic [ADDR_W-1:0]     read_incr_i,
   input  logic [ADDR_W-1:0]     read_shift_i,
   input  logic [ADDR_W-1:0]     read_iter_i,
   input  logic [DATA_W-1:0]     in_data_i,
   output logic                  mem_wr_o,
   output logic [ADDR_W-1:0]     mem_wr_addr_o,
   output logic [DATA_W-1:0]     mem_wr_data_o,
   output logic                  mem_rd_o,
   output logic [ADDR_W-1:0]     mem_rd_addr_o,
   input  logic [DATA_W-1:0]     mem_rd_data_i,
   output logic                  bus_valid_o,
   input  logic                  bus_ready_i,
   output logic [AXI_ADDR_W-1:0] bus_addr_o,
   output logic [DATA_W-1:0]     bus_wdata_o,
   output logic [DATA_W/8-1:0]   bus_wstrb_o,
   output logic [LEN_W-1:0]      bus_len_o,
   input  logic                  bus_last_i
);

   vwrite_pkg::gen_cfg_t store_cfg;
   vwrite_pkg::gen_cfg_t read_cfg;

   logic              read_run;
   logic              store_valid;
   logic              store_flag;
   logic              store_done;
   logic              xfer_done;
   logic [ADDR_W-1:0] store_addr_raw;
   logic              read_valid;
   logic              read_ready;
   logic [ADDR_W-1:0] read_addr_raw;
   logic [ADDR_W-1:0] read_addr;
   logic [ADDR_W-1:0] word_count;

   word_stream_if #(.DATA_W(DATA_W)) rd_stream ();

   assign store_cfg.start  = store_start_i;
   assign store_cfg.period = store_per_i;
   assign store_cfg.duty   = store_duty_i;
   assign store_cfg.incr   = store_incr_i;
   assign store_cfg.shift  = store_shift_i;
   assign store_cfg.iter   = store_iter_i;
   assign store_cfg.delay  = store_delay_i;

   // read side stores on every step and starts at once
   assign read_cfg.start  = read_start_i;
   assign read_cfg.period = read_per_i;
   assign read_cfg.duty   = read_per_i;
   assign read_cfg.incr   = read_incr_i;
   assign read_cfg.shift  = read_shift_i;
   assign read_cfg.iter   = read_iter_i;
   assign read_cfg.delay  = '0;

   assign word_count = amount_minus_one_i + ADDR_W'(1);

   write_ctrl #(
      .ADDR_W(ADDR_W)
   ) ctrl (
      .clk           (clk),
      .rst           (rst),
      .run_i         (run_i),
      .running_i     (running_i),
      .ping_pong_i   (ping_pong_i),
      .write_enable_i(write_enable_i),
      .store_done_i  (store_done),
      .xfer_done_i   (xfer_done),
      .store_addr_i  (store_addr_raw),
      .read_addr_i   (read_addr_raw),
      .done_o        (done_o),
      .read_run_o    (read_run),
      .store_addr_o  (mem_wr_addr_o),
      .read_addr_o   (read_addr)
   );

   addr_gen #(
      .ADDR_W  (ADDR_W),
      .PERIOD_W(PERIOD_W),
      .DELAY_W (DELAY_W)
   ) store_gen (
      .clk    (clk),
      .rst    (rst),
      .run_i  (run_i),
      .cfg_i  (store_cfg),
      .ready_i(1'b1),
      .valid_o(store_valid),
      .addr_o (store_addr_raw),
      .store_o(store_flag),
      .done_o (store_done)
   );

   // input word lands in the buffer on the step itself
   assign mem_wr_o      = store_valid && store_flag;
   assign mem_wr_data_o = in_data_i;

   addr_gen #(
      .ADDR_W  (ADDR_W),
      .PERIOD_W(PERIOD_W),
      .DELAY_W (DELAY_W)
   ) read_gen (
      .clk    (clk),
      .rst    (rst),
      .run_i  (read_run),
      .cfg_i  (read_cfg),
      .ready_i(read_ready),
      .valid_o(read_valid),
      .addr_o (read_addr_raw),
      .store_o(),
      .done_o ()
   );

   mem_reader #(
      .ADDR_W(ADDR_W),
      .DATA_W(DATA_W)
   ) reader (
      .clk        (clk),
      .rst        (rst),
      .gen_valid_i(read_valid),
      .gen_addr_i (read_addr),
      .mem_data_i (mem_rd_data_i),
      .gen_ready_o(read_ready),
      .mem_en_o   (mem_rd_o),
      .mem_addr_o (mem_rd_addr_o),
      .out        (rd_stream.src)
   );

   burst_writer #(
      .ADDR_W    (ADDR_W),
      .DATA_W    (DATA_W),
      .AXI_ADDR_W(AXI_ADDR_W),
      .LEN_W     (LEN_W)
   ) writer (
      .clk         (clk),
      .rst         (rst),
      .run_i       (read_run),
      .count_i     (word_count),
      .start_addr_i(ext_addr_i),
      .addr_shift_i(addr_shift_i),
      .burst_len_i (burst_len_i),
      .bus_ready_i (bus_ready_i),
      .bus_last_i  (bus_last_i),
      .bus_valid_o (bus_valid_o),
      .bus_addr_o  (bus_addr_o),
      .bus_wdata_o (bus_wdata_o),
      .bus_wstrb_o (bus_wstrb_o),
      .bus_len_o   (bus_len_o),
      .done_o      (xfer_done),
      .in          (rd_stream.snk)
   );

endmodule

// ==== verilog/write_ctrl.sv ====
module write_ctrl #(
   parameter int ADDR_W = 10
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              run_i,
   input  logic              running_i,
   input  logic              ping_pong_i,
   input  logic              write_enable_i,
   input  logic              store_done_i,
   input  logic              xfer_done_i,
   input  logic [ADDR_W-1:0] store_addr_i,
   input  logic [ADDR_W-1:0] read_addr_i,
   output logic              done_o,
   output logic              read_run_o,
   output logic [ADDR_W-1:0] store_addr_o,
   output logic [ADDR_W-1:0] read_addr_o
);

   logic store_done_q;
   // bank the store side fills in this run
   logic bank_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         store_done_q <= 1'b1;
      end else if (run_i) begin
         store_done_q <= 1'b0;
      end else if (running_i) begin
         store_done_q <= store_done_i;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bank_q <= 1'b0;
      end else if (run_i) begin
         bank_q <= ping_pong_i ? !bank_q : 1'b0;
      end
   end

   // transfer done stays high when writing is off
   assign done_o     = store_done_q && xfer_done_i;
   assign read_run_o = run_i && write_enable_i;

   // top address bit selects the bank under ping-pong
   assign store_addr_o = ping_pong_i ? {bank_q, store_addr_i[ADDR_W-2:0]} : store_addr_i;
   assign read_addr_o  = ping_pong_i ? {!bank_q, read_addr_i[ADDR_W-2:0]} : read_addr_i;

endmodule

// ==== verilog/burst_writer.sv ====
module burst_writer #(
   parameter int ADDR_W     = 10,
   parameter int DATA_W     = 32,
   parameter int AXI_ADDR_W = 32,
   parameter int LEN_W      = 8
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  run_i,
   input  logic [ADDR_W-1:0]     count_i,
   input  logic [AXI_ADDR_W-1:0] start_addr_i,
   input  logic [AXI_ADDR_W-1:0] addr_shift_i,
   input  logic [LEN_W-1:0]      burst_len_i,
   input  logic                  bus_ready_i,
   input  logic                  bus_last_i,
   output logic                  bus_valid_o,
   output logic [AXI_ADDR_W-1:0] bus_addr_o,
   output logic [DATA_W-1:0]     bus_wdata_o,
   output logic [DATA_W/8-1:0]   bus_wstrb_o,
   output logic [LEN_W-1:0]      bus_len_o,
   output logic                  done_o,
   word_stream_if.snk            in
);

   logic                  active_q;
   logic                  done_q;
   logic [ADDR_W-1:0]     remain_q;
   logic [LEN_W-1:0]      beat_q;
   logic [AXI_ADDR_W-1:0] addr_q;
   logic                  beat_fire;
   logic                  final_word;
   logic                  burst_end;

   // beats pass straight from the stream to the bus
   assign bus_valid_o = active_q && in.valid;
   assign in.ready    = active_q && bus_ready_i;
   assign beat_fire   = bus_valid_o && bus_ready_i;

   assign final_word = (remain_q == ADDR_W'(1));
   // slave may close a burst early with last
   assign burst_end  = bus_last_i || (beat_q == burst_len_i - LEN_W'(1));
   assign in.last    = active_q && final_word;

   assign bus_addr_o  = addr_q;
   assign bus_wdata_o = in.data;
   assign bus_wstrb_o = '1;
   assign bus_len_o   = burst_len_i;
   assign done_o      = done_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         active_q <= 1'b0;
         done_q   <= 1'b1;
         remain_q <= '0;
         beat_q   <= '0;
      end else if (run_i) begin
         active_q <= (count_i != '0);
         done_q   <= (count_i == '0);
         remain_q <= count_i;
         beat_q   <= '0;
      end else if (beat_fire) begin
         remain_q <= remain_q - ADDR_W'(1);
         if (final_word) begin
            active_q <= 1'b0;
            done_q   <= 1'b1;
         end else if (burst_end) begin
            beat_q <= '0;
         end else begin
            beat_q <= beat_q + LEN_W'(1);
         end
      end
   end

   // burst address steps once per completed burst
   always_ff @(posedge clk) begin
      if (run_i) begin
         addr_q <= start_addr_i;
      end else if (beat_fire && burst_end && !final_word) begin
         addr_q <= addr_q + addr_shift_i;
      end
   end

endmodule

// ==== verilog/mem_reader.sv ====
module mem_reader #(
   parameter int ADDR_W = 10,
   parameter int DATA_W = 32
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              gen_valid_i,
   input  logic [ADDR_W-1:0] gen_addr_i,
   input  logic [DATA_W-1:0] mem_data_i,
   output logic              gen_ready_o,
   output logic              mem_en_o,
   output logic [ADDR_W-1:0] mem_addr_o,
   word_stream_if.src        out
);

   // word returning from the buffer this cycle
   logic              pend_q;
   logic              skid_valid_q;
   logic [DATA_W-1:0] skid_data_q;
   logic              out_fire;
   logic              flush;

   assign out.valid = skid_valid_q || pend_q;
   assign out.data  = skid_valid_q ? skid_data_q : mem_data_i;
   assign out_fire  = out.valid && out.ready;
   assign flush     = out_fire && out.last;

   // at most one word may be held once the consumer stalls
   assign gen_ready_o = out.ready || !(skid_valid_q || pend_q);
   assign mem_en_o    = gen_valid_i && gen_ready_o;
   assign mem_addr_o  = gen_addr_i;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pend_q       <= 1'b0;
         skid_valid_q <= 1'b0;
      end else if (flush) begin
         // nothing survives the end of a run
         pend_q       <= 1'b0;
         skid_valid_q <= 1'b0;
      end else begin
         pend_q <= mem_en_o;
         if (skid_valid_q) begin
            if (out.ready) begin
               skid_valid_q <= pend_q;
            end
         end else if (pend_q && !out.ready) begin
            skid_valid_q <= 1'b1;
         end
      end
   end

   // park the returned word when it cannot go out directly
   always_ff @(posedge clk) begin
      if (pend_q && (skid_valid_q == out.ready)) begin
         skid_data_q <= mem_data_i;
      end
   end

endmodule

// ==== verilog/addr_gen.sv ====
module addr_gen #(
   parameter int ADDR_W   = 10,
   parameter int PERIOD_W = 8,
   parameter int DELAY_W  = 7
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 run_i,
   input  vwrite_pkg::gen_cfg_t cfg_i,
   input  logic                 ready_i,
   output logic                 valid_o,
   output logic [ADDR_W-1:0]    addr_o,
   output logic                 store_o,
   output logic                 done_o
);

   logic                active_q;
   logic                done_q;
   logic [DELAY_W-1:0]  delay_q;
   logic [PERIOD_W-1:0] step_q;
   logic [ADDR_W-1:0]   iter_q;
   logic [ADDR_W-1:0]   addr_q;
   logic [ADDR_W-1:0]   base_q;
   logic                fire;
   logic                step_last;
   logic                iter_last;
   logic                cfg_empty;

   // steps are offered once the delay has run out
   assign valid_o   = active_q && (delay_q == '0);
   assign fire      = valid_o && ready_i;
   assign step_last = (step_q == cfg_i.period - PERIOD_W'(1));
   assign iter_last = (iter_q == cfg_i.iter - ADDR_W'(1));
   assign cfg_empty = (cfg_i.period == '0) || (cfg_i.iter == '0);

   assign addr_o  = addr_q;
   assign store_o = (step_q < cfg_i.duty);
   assign done_o  = done_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         active_q <= 1'b0;
         done_q   <= 1'b1;
         delay_q  <= '0;
         step_q   <= '0;
         iter_q   <= '0;
      end else if (run_i) begin
         // a loop with no steps finishes at once
         active_q <= !cfg_empty;
         done_q   <= cfg_empty;
         delay_q  <= cfg_i.delay;
         step_q   <= '0;
         iter_q   <= '0;
      end else if (active_q) begin
         if (delay_q != '0) begin
            delay_q <= delay_q - DELAY_W'(1);
         end else if (fire) begin
            if (!step_last) begin
               step_q <= step_q + PERIOD_W'(1);
            end else begin
               step_q <= '0;
               if (iter_last) begin
                  active_q <= 1'b0;
                  done_q   <= 1'b1;
               end else begin
                  iter_q <= iter_q + ADDR_W'(1);
               end
            end
         end
      end
   end

   // running address and iteration base
   always_ff @(posedge clk) begin
      if (run_i) begin
         addr_q <= cfg_i.start;
         base_q <= cfg_i.start;
      end else if (fire) begin
         if (step_last) begin
            addr_q <= base_q + cfg_i.shift;
            base_q <= base_q + cfg_i.shift;
         end else begin
            addr_q <= addr_q + cfg_i.incr;
         end
      end
   end

endmodule

// ==== verilog/word_stream_if.sv ====
interface word_stream_if #(
   parameter int DATA_W = vwrite_pkg::DATA_W
);

   logic              valid;
   logic              ready;
   logic [DATA_W-1:0] data;
   // final word of the run as flagged by the consumer
   logic              last;

   modport src (
      output valid,
      output data,
      input  ready,
      input  last
   );

   modport snk (
      input  valid,
      input  data,
      output ready,
      output last
   );

endinterface

// ==== verilog/vwrite_pkg.sv ====
package vwrite_pkg;

   // buffer address width
   localparam int ADDR_W = 10;

   // stream and buffer word width
   localparam int DATA_W = 32;

   // databus address width
   localparam int AXI_ADDR_W = 32;

   // period and duty counters
   localparam int PERIOD_W = 8;

   // burst length field on the databus
   localparam int LEN_W = 8;

   // start delay of a generator
   localparam int DELAY_W = 7;

   // one loop of an address generator
   typedef struct packed {
      logic [ADDR_W-1:0]   start;
      logic [PERIOD_W-1:0] period;
      // steps per period that store
      logic [PERIOD_W-1:0] duty;
      logic [ADDR_W-1:0]   incr;
      // base step between iterations
      logic [ADDR_W-1:0]   shift;
      logic [ADDR_W-1:0]   iter;
      logic [DELAY_W-1:0]  delay;
   } gen_cfg_t;

endpackage
